// ==== all.f ====
+incdir+design
design/rv_core_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/reg_file.sv
design/exec_unit.sv
design/rv_core_top.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vrv_core_tb
SRCS := $(shell grep -v '^+' all.f) design/rv_core_macros.svh

all: run

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module rv_core_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== verif/rv_core_tb.sv ====
`include "rv_core_macros.svh"

module rv_core_tb import rv_core_pkg::*;;

  localparam int RESET_CYCLES = 5;
  localparam int HALT_WATCH   = 8;
  localparam int OPI          = 'h13;
  localparam int JALR         = 'h67;

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  logic     ibus_ack = 1'b0;
  inst_t    ibus_dat = '0;
  logic     ibus_cyc;
  logic     ibus_stb;
  xlen_t    ibus_adr;
  logic     retire;
  xlen_t    retire_pc;
  logic     rd_we;
  reg_idx_t rd_idx;
  xlen_t    rd_data;
  logic     halt;
  logic     illegal;

  // instruction memory and slave state
  inst_t      mem [0:63];
  logic       pending = 1'b0;
  logic [1:0] wait_cnt = 2'd0;
  logic [1:0] delay;
  logic [7:0] lfsr = 8'd6;

  // program table with one row per retired instruction
  inst_t    tab_inst[$];
  xlen_t    tab_pc[$];
  logic     tab_we[$];
  reg_idx_t tab_rd[$];
  xlen_t    tab_data[$];
  int       seg_start[$];
  logic     seg_illegal[$];
  int       checks = 0;
  int       errors = 0;

  always #10 clk = ~clk;

  rv_core_top dut_i (
    .clk         (clk),
    .rst_i       (rst),
    .ibus_ack_i  (ibus_ack),
    .ibus_dat_i  (ibus_dat),
    .ibus_cyc_o  (ibus_cyc),
    .ibus_stb_o  (ibus_stb),
    .ibus_adr_o  (ibus_adr),
    .retire_o    (retire),
    .retire_pc_o (retire_pc),
    .rd_we_o     (rd_we),
    .rd_idx_o    (rd_idx),
    .rd_data_o   (rd_data),
    .halt_o      (halt),
    .illegal_o   (illegal)
  );

  // right shifting x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
  endfunction

  // opcode 0 is never a legal word
  function automatic inst_t fill_word(input xlen_t adr);
    return {adr[24:0] ^ adr[49:25] ^ {11'b0, adr[63:50]}, 7'b0000000};
  endfunction

  function automatic inst_t mem_word(input xlen_t adr);
    if (adr[63:8] == '0) begin
      return mem[adr[7:2]];
    end else begin
      return fill_word(adr);
    end
  endfunction

  // wishbone classic slave with 0 to 3 extra wait cycles
  always @(posedge clk) begin
    if (rst) begin
      ibus_ack <= 1'b0;
      pending  <= 1'b0;
    end else if (ibus_ack) begin
      ibus_ack <= 1'b0;
      pending  <= 1'b0;
    end else if (ibus_cyc && ibus_stb) begin
      if (!pending) begin
        delay[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        delay[1] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        pending  <= 1'b1;
        wait_cnt <= delay;
      end else if (wait_cnt == 2'd0) begin
        ibus_ack <= 1'b1;
        ibus_dat <= mem_word(ibus_adr);
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

  function automatic inst_t op_r(input int f7, input int f3, input int rd, input int rs1,
                                 input int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
  endfunction

  function automatic inst_t op_i(input int opc, input int f3, input int rd, input int rs1,
                                 input int imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(opc)};
  endfunction

  function automatic inst_t op_b(input int f3, input int rs1, input int rs2, input int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic inst_t op_j(input int rd, input int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
  endfunction

  task automatic add_entry(input inst_t w, input int pc, input logic we, input int rd,
                           input xlen_t data);
    tab_inst.push_back(w);
    tab_pc.push_back(xlen_t'(pc));
    tab_we.push_back(we);
    tab_rd.push_back(reg_idx_t'(rd));
    tab_data.push_back(data);
  endtask

  task automatic start_segment(input logic ill);
    seg_start.push_back(tab_inst.size());
    seg_illegal.push_back(ill);
  endtask

  task automatic build_program();
    start_segment(1'b1);
    // x5 reads as zero after reset
    add_entry(op_i(OPI, 0, 31, 0, 1), 'h00, 1'b1, 31, 64'h1);
    add_entry(op_r(0, 0, 2, 31, 5), 'h04, 1'b1, 2, 64'h1);
    // a load is outside the kept set
    add_entry(32'h0000_2083, 'h08, 1'b0, 0, 64'h0);
    // x31 cleared again by the second reset
    start_segment(1'b0);
    add_entry(op_i(OPI, 0, 1, 31, 'h7ff), 'h00, 1'b1, 1, 64'h7ff);
    add_entry(op_i(OPI, 0, 2, 0, -1), 'h04, 1'b1, 2, 64'hffff_ffff_ffff_ffff);
    add_entry({20'h80000, 5'd3, 7'b0110111}, 'h08, 1'b1, 3, 64'hffff_ffff_8000_0000);
    add_entry(op_r('h20, 0, 4, 1, 2), 'h0c, 1'b1, 4, 64'h800);
    add_entry(op_r(0, 4, 5, 1, 2), 'h10, 1'b1, 5, 64'hffff_ffff_ffff_f800);
    add_entry(op_r(0, 6, 6, 3, 1), 'h14, 1'b1, 6, 64'hffff_ffff_8000_07ff);
    add_entry(op_r(0, 7, 7, 5, 6), 'h18, 1'b1, 7, 64'hffff_ffff_8000_0000);
    add_entry(op_r(0, 2, 8, 2, 1), 'h1c, 1'b1, 8, 64'h1);
    add_entry(op_r(0, 3, 9, 2, 1), 'h20, 1'b1, 9, 64'h0);
    add_entry(op_i(OPI, 2, 10, 3, -1), 'h24, 1'b1, 10, 64'h1);
    add_entry(op_i(OPI, 3, 11, 1, -1), 'h28, 1'b1, 11, 64'h1);
    // shift amounts above 31
    add_entry(op_i(OPI, 1, 12, 1, 53), 'h2c, 1'b1, 12, 64'hffe0_0000_0000_0000);
    add_entry(op_i(OPI, 5, 13, 12, 'h424), 'h30, 1'b1, 13, 64'hffff_ffff_fffe_0000);
    add_entry(op_i(OPI, 5, 14, 12, 36), 'h34, 1'b1, 14, 64'h0ffe_0000);
    add_entry(op_i(OPI, 0, 15, 0, 40), 'h38, 1'b1, 15, 64'h28);
    add_entry(op_r('h20, 5, 16, 12, 15), 'h3c, 1'b1, 16, 64'hffff_ffff_ffff_e000);
    add_entry(op_r(0, 5, 17, 12, 15), 'h40, 1'b1, 17, 64'hff_e000);
    add_entry(op_r(0, 1, 18, 1, 15), 'h44, 1'b1, 18, 64'h0007_ff00_0000_0000);
    add_entry(op_r(0, 0, 19, 3, 3), 'h48, 1'b1, 19, 64'hffff_ffff_0000_0000);
    add_entry(op_i(OPI, 7, 20, 6, 'h0f0), 'h4c, 1'b1, 20, 64'hf0);
    add_entry(op_i(OPI, 6, 21, 0, -2048), 'h50, 1'b1, 21, 64'hffff_ffff_ffff_f800);
    add_entry(op_i(OPI, 4, 22, 1, -1), 'h54, 1'b1, 22, 64'hffff_ffff_ffff_f800);
    // x0 stays zero
    add_entry(op_i(OPI, 0, 0, 1, 5), 'h58, 1'b0, 0, 64'h0);
    add_entry(op_r(0, 0, 23, 0, 1), 'h5c, 1'b1, 23, 64'h7ff);
    // taken branches skip one word
    add_entry(op_b(0, 21, 22, 8), 'h60, 1'b0, 0, 64'h0);
    add_entry(op_b(1, 21, 22, 8), 'h68, 1'b0, 0, 64'h0);
    add_entry(op_b(4, 2, 1, 8), 'h6c, 1'b0, 0, 64'h0);
    add_entry(op_b(6, 2, 1, 8), 'h74, 1'b0, 0, 64'h0);
    add_entry(op_b(5, 1, 2, 8), 'h78, 1'b0, 0, 64'h0);
    add_entry(op_b(7, 1, 2, 8), 'h80, 1'b0, 0, 64'h0);
    add_entry(op_b(6, 1, 2, 8), 'h84, 1'b0, 0, 64'h0);
    add_entry(op_b(5, 2, 1, 8), 'h8c, 1'b0, 0, 64'h0);
    add_entry(op_b(7, 2, 1, 8), 'h90, 1'b0, 0, 64'h0);
    add_entry(op_b(4, 1, 2, 8), 'h98, 1'b0, 0, 64'h0);
    add_entry(op_b(0, 1, 2, 8), 'h9c, 1'b0, 0, 64'h0);
    add_entry(op_b(1, 1, 2, 12), 'ha0, 1'b0, 0, 64'h0);
    add_entry(op_j(24, 12), 'hac, 1'b1, 24, 64'hb0);
    add_entry(op_i(OPI, 0, 25, 0, 'hc5), 'hb8, 1'b1, 25, 64'hc5);
    // target 0xc9 lands on 0xc8
    add_entry(op_i(JALR, 0, 26, 25, 4), 'hbc, 1'b1, 26, 64'hc0);
    add_entry(op_r(0, 0, 27, 24, 26), 'hc8, 1'b1, 27, 64'h170);
    add_entry(32'h0010_0073, 'hcc, 1'b0, 0, 64'h0);
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic load_memory(input int first, input int last);
    xlen_t a;
    for (int k = 0; k < 64; k++) begin
      mem[k] = fill_word(xlen_t'(k) << 2);
    end
    for (int i = first; i < last; i++) begin
      a = tab_pc[i];
      mem[a[7:2]] = tab_inst[i];
    end
  endtask

  task automatic run_segment(input int first, input int last, input logic exp_illegal);
    @(posedge clk);
    rst <= 1'b1;
    load_memory(first, last);
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("ibus_cyc_o", ibus_cyc, 1'b0);
    check_bit("ibus_stb_o", ibus_stb, 1'b0);
    check_bit("retire_o", retire, 1'b0);
    check_bit("halt_o", halt, 1'b0);
    check_bit("illegal_o", illegal, 1'b0);
    for (int i = first; i < last; i++) begin
      @(negedge clk);
      while (!retire) @(negedge clk);
      check_word("retire_pc_o", retire_pc, tab_pc[i]);
      check_bit("rd_we_o", rd_we, tab_we[i]);
      check_bit("halt_o", halt, 1'b0);
      if (tab_we[i]) begin
        check_idx("rd_idx_o", rd_idx, tab_rd[i]);
        check_word("rd_data_o", rd_data, tab_data[i]);
      end
    end
    // last word halts the core for good
    @(negedge clk);
    check_bit("halt_o", halt, 1'b1);
    check_bit("illegal_o", illegal, exp_illegal);
    repeat (HALT_WATCH) begin
      @(negedge clk);
      check_bit("ibus_cyc_o", ibus_cyc, 1'b0);
      check_bit("ibus_stb_o", ibus_stb, 1'b0);
    end
  endtask

  initial begin : watchdog
    int limit;
    #1;
    limit = tab_inst.size() * 8 * 20 + seg_start.size() * (RESET_CYCLES + HALT_WATCH + 4) * 20;
    #(limit);
    $display("ERROR: timed out after %0d time units waiting for the core to retire", limit);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int last;
    build_program();
    for (int s = 0; s < seg_start.size(); s++) begin
      last = (s + 1 < seg_start.size()) ? seg_start[s + 1] : tab_inst.size();
      run_segment(seg_start[s], last, seg_illegal[s]);
    end
    $display("checks run: %0d, mismatches: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/rv_core_properties.sv ====
module rv_core_properties import rv_core_pkg::*; (
  input logic  clk,
  input logic  rst_i,
  input logic  ibus_cyc_o,
  input logic  ibus_stb_o,
  input xlen_t ibus_adr_o,
  input logic  ibus_ack_i,
  input logic  retire_o,
  input logic  halt_o
);

  stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
    ibus_stb_o |-> ibus_cyc_o)
    else $error("ibus_stb_o high outside a bus cycle");

  // master holds the request until ack
  adr_held: assert property (@(posedge clk) disable iff (rst_i)
    (ibus_stb_o && !ibus_ack_i) |=> (ibus_stb_o && $stable(ibus_adr_o)))
    else $error("request dropped or address changed before ack");

  retire_single: assert property (@(posedge clk) disable iff (rst_i)
    retire_o |=> !retire_o)
    else $error("retire_o high on two cycles in a row");

  no_cyc_halted: assert property (@(posedge clk) disable iff (rst_i)
    halt_o |-> !ibus_cyc_o)
    else $error("bus cycle started while halted");

endmodule

bind rv_core_top rv_core_properties props_i (
  .clk        (clk),
  .rst_i      (rst_i),
  .ibus_cyc_o (ibus_cyc_o),
  .ibus_stb_o (ibus_stb_o),
  .ibus_adr_o (ibus_adr_o),
  .ibus_ack_i (ibus_ack_i),
  .retire_o   (retire_o),
  .halt_o     (halt_o)
);

// ==== design/rv_core_top.sv ====
module rv_core_top import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     ibus_ack_i,
  input  inst_t    ibus_dat_i,
  output logic     ibus_cyc_o,
  output logic     ibus_stb_o,
  output xlen_t    ibus_adr_o,
  output logic     retire_o,
  output xlen_t    retire_pc_o,
  output logic     rd_we_o,
  output reg_idx_t rd_idx_o,
  output xlen_t    rd_data_o,
  output logic     halt_o,
  output logic     illegal_o
);

  inst_t     inst;
  xlen_t     pc;
  logic      exec;
  logic      jump;
  xlen_t     jump_addr;
  logic      ebreak;
  logic      dec_illegal;
  logic      dec_rd_we;
  reg_idx_t  rs1_idx;
  reg_idx_t  rs2_idx;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  exu_info_t info;
  xlen_t     op1;
  xlen_t     op2;
  xlen_t     op1_jp;
  xlen_t     op2_jp;

  // writes only land in the single exec cycle
  assign rd_we_o     = dec_rd_we & exec;
  assign retire_o    = exec;
  assign retire_pc_o = pc;

  fetch_unit u_fetch (
    .clk         (clk),
    .rst_i       (rst_i),
    .ibus_ack_i  (ibus_ack_i),
    .ibus_dat_i  (ibus_dat_i),
    .jump_i      (jump),
    .jump_addr_i (jump_addr),
    .stop_i      (ebreak),
    .illegal_i   (dec_illegal),
    .ibus_cyc_o  (ibus_cyc_o),
    .ibus_stb_o  (ibus_stb_o),
    .ibus_adr_o  (ibus_adr_o),
    .inst_o      (inst),
    .pc_o        (pc),
    .exec_o      (exec),
    .halt_o      (halt_o),
    .illegal_o   (illegal_o)
  );

  decode_unit u_decode (
    .inst_i     (inst),
    .pc_i       (pc),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .rd_idx_o   (rd_idx_o),
    .rd_we_o    (dec_rd_we),
    .info_o     (info),
    .op1_o      (op1),
    .op2_o      (op2),
    .op1_jp_o   (op1_jp),
    .op2_jp_o   (op2_jp),
    .illegal_o  (dec_illegal)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst_i    (rst_i),
    .we_i     (rd_we_o),
    .waddr_i  (rd_idx_o),
    .wdata_i  (rd_data_o),
    .raddr1_i (rs1_idx),
    .raddr2_i (rs2_idx),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  exec_unit u_exec (
    .info_i      (info),
    .op1_i       (op1),
    .op2_i       (op2),
    .op1_jp_i    (op1_jp),
    .op2_jp_i    (op2_jp),
    .alu_res_o   (rd_data_o),
    .jump_o      (jump),
    .jump_addr_o (jump_addr),
    .ebreak_o    (ebreak)
  );

endmodule

// ==== design/exec_unit.sv ====
`include "rv_core_macros.svh"

module exec_unit import rv_core_pkg::*; (
  input  exu_info_t info_i,
  input  xlen_t     op1_i,
  input  xlen_t     op2_i,
  input  xlen_t     op1_jp_i,
  input  xlen_t     op2_jp_i,
  output xlen_t     alu_res_o,
  output logic      jump_o,
  output xlen_t     jump_addr_o,
  output logic      ebreak_o
);

  logic              alu_req;
  logic              bjp_req;
  logic              op_add;
  logic              op_sub;
  logic              op_slt;
  logic              op_unsigned;
  logic              op_jal;
  logic              op_jalr;
  logic              branch_taken;
  logic              cmp_eq;
  logic              cmp_lt;
  logic [`RV_XLEN:0] adder_a;
  logic [`RV_XLEN:0] adder_b;
  logic [`RV_XLEN:0] adder_sum;
  xlen_t             jp_sum;

  assign alu_req = (info_i[2:0] == `EXU_GRP_ALU);
  assign bjp_req = (info_i[2:0] == `EXU_GRP_BJP);

  assign op_jal  = bjp_req & info_i[`EXU_BJP_JAL];
  assign op_jalr = bjp_req & info_i[`EXU_BJP_JALR];
  assign op_slt  = alu_req & (info_i[`EXU_ALU_SLT] | info_i[`EXU_ALU_SLTU]);

  // jal/jalr reuse the adder for the link value
  assign op_add = (alu_req & info_i[`EXU_ALU_ADD]) | op_jal | op_jalr;

  // every compare is a subtract
  assign op_sub = (alu_req & info_i[`EXU_ALU_SUB]) | op_slt |
                  (bjp_req & (|info_i[`EXU_BJP_BGEU:`EXU_BJP_BEQ]));

  assign op_unsigned = (alu_req & info_i[`EXU_ALU_SLTU]) |
                       (bjp_req & (info_i[`EXU_BJP_BLTU] | info_i[`EXU_BJP_BGEU]));

  // 65 bit adder with a zero extension bit for unsigned compares
  assign adder_a   = {op1_i[`RV_XLEN-1] & ~op_unsigned, op1_i};
  assign adder_b   = {op2_i[`RV_XLEN-1] & ~op_unsigned, op2_i};
  assign adder_sum = adder_a + (op_sub ? ~adder_b : adder_b) + {{`RV_XLEN{1'b0}}, op_sub};

  assign cmp_lt = adder_sum[`RV_XLEN];
  assign cmp_eq = (adder_sum[`RV_XLEN-1:0] == '0);

  // each condition only counts under its own operation
  assign branch_taken = bjp_req & ((info_i[`EXU_BJP_BEQ]  &  cmp_eq) |
                                   (info_i[`EXU_BJP_BNE]  & ~cmp_eq) |
                                   (info_i[`EXU_BJP_BLT]  &  cmp_lt) |
                                   (info_i[`EXU_BJP_BGE]  & ~cmp_lt) |
                                   (info_i[`EXU_BJP_BLTU] &  cmp_lt) |
                                   (info_i[`EXU_BJP_BGEU] & ~cmp_lt));

  assign alu_res_o =
      ({`RV_XLEN{op_add | (alu_req & info_i[`EXU_ALU_SUB])}} & adder_sum[`RV_XLEN-1:0]) |
      ({`RV_XLEN{alu_req & info_i[`EXU_ALU_SLL]}} & (op1_i << op2_i[5:0])) |
      ({`RV_XLEN{op_slt}} & {{(`RV_XLEN-1){1'b0}}, cmp_lt}) |
      ({`RV_XLEN{alu_req & info_i[`EXU_ALU_XOR]}} & (op1_i ^ op2_i)) |
      ({`RV_XLEN{alu_req & info_i[`EXU_ALU_SRL]}} & (op1_i >> op2_i[5:0])) |
      ({`RV_XLEN{alu_req & info_i[`EXU_ALU_SRA]}} & xlen_t'($signed(op1_i) >>> op2_i[5:0])) |
      ({`RV_XLEN{alu_req & info_i[`EXU_ALU_OR]}}  & (op1_i | op2_i)) |
      ({`RV_XLEN{alu_req & info_i[`EXU_ALU_AND]}} & (op1_i & op2_i)) |
      ({`RV_XLEN{alu_req & info_i[`EXU_ALU_LUI]}} & op2_i);

  // jalr drops bit 0 of the jump target
  assign jp_sum      = op1_jp_i + op2_jp_i;
  assign jump_addr_o = {jp_sum[`RV_XLEN-1:1], jp_sum[0] & ~op_jalr};
  assign jump_o      = op_jal | op_jalr | branch_taken;

  assign ebreak_o = info_i[`EXU_EBREAK];

endmodule

// ==== design/reg_file.sv ====
module reg_file import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     we_i,
  input  reg_idx_t waddr_i,
  input  xlen_t    wdata_i,
  input  reg_idx_t raddr1_i,
  input  reg_idx_t raddr2_i,
  output xlen_t    rdata1_o,
  output xlen_t    rdata2_o
);

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== design/decode_unit.sv ====
`include "rv_core_macros.svh"

module decode_unit import rv_core_pkg::*; (
  input  inst_t     inst_i,
  input  xlen_t     pc_i,
  input  xlen_t     rs1_data_i,
  input  xlen_t     rs2_data_i,
  output reg_idx_t  rs1_idx_o,
  output reg_idx_t  rs2_idx_o,
  output reg_idx_t  rd_idx_o,
  output logic      rd_we_o,
  output exu_info_t info_o,
  output xlen_t     op1_o,
  output xlen_t     op2_o,
  output xlen_t     op1_jp_o,
  output xlen_t     op2_jp_o,
  output logic      illegal_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;
  xlen_t      imm_i;
  xlen_t      imm_b;
  xlen_t      imm_j;
  xlen_t      imm_u;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  // rv64 shifts use a 6 bit shamt
  assign funct6 = inst_i[31:26];

  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];
  assign rd_idx_o  = inst_i[11:7];

  assign imm_i = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_b = {{(`RV_XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                  inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                  inst_i[20], inst_i[30:21], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

  always_comb begin
    info_o    = '0;
    illegal_o = 1'b0;
    rd_we_o   = 1'b0;
    op1_o     = rs1_data_i;
    op2_o     = rs2_data_i;
    op1_jp_o  = pc_i;
    op2_jp_o  = imm_b;
    case (opcode)
      OPC_OP: begin
        info_o[2:0] = `EXU_GRP_ALU;
        rd_we_o     = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: info_o[`EXU_ALU_ADD]  = 1'b1;
          {7'b0100000, 3'b000}: info_o[`EXU_ALU_SUB]  = 1'b1;
          {7'b0000000, 3'b001}: info_o[`EXU_ALU_SLL]  = 1'b1;
          {7'b0000000, 3'b010}: info_o[`EXU_ALU_SLT]  = 1'b1;
          {7'b0000000, 3'b011}: info_o[`EXU_ALU_SLTU] = 1'b1;
          {7'b0000000, 3'b100}: info_o[`EXU_ALU_XOR]  = 1'b1;
          {7'b0000000, 3'b101}: info_o[`EXU_ALU_SRL]  = 1'b1;
          {7'b0100000, 3'b101}: info_o[`EXU_ALU_SRA]  = 1'b1;
          {7'b0000000, 3'b110}: info_o[`EXU_ALU_OR]   = 1'b1;
          {7'b0000000, 3'b111}: info_o[`EXU_ALU_AND]  = 1'b1;
          default:              illegal_o             = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        info_o[2:0] = `EXU_GRP_ALU;
        rd_we_o     = 1'b1;
        op2_o       = imm_i;
        case (funct3)
          3'b000: info_o[`EXU_ALU_ADD]  = 1'b1;
          3'b010: info_o[`EXU_ALU_SLT]  = 1'b1;
          3'b011: info_o[`EXU_ALU_SLTU] = 1'b1;
          3'b100: info_o[`EXU_ALU_XOR]  = 1'b1;
          3'b110: info_o[`EXU_ALU_OR]   = 1'b1;
          3'b111: info_o[`EXU_ALU_AND]  = 1'b1;
          3'b001:
            if (funct6 == 6'b000000) info_o[`EXU_ALU_SLL] = 1'b1;
            else illegal_o = 1'b1;
          default:
            if (funct6 == 6'b000000) info_o[`EXU_ALU_SRL] = 1'b1;
            else if (funct6 == 6'b010000) info_o[`EXU_ALU_SRA] = 1'b1;
            else illegal_o = 1'b1;
        endcase
      end
      OPC_LUI: begin
        info_o[2:0]          = `EXU_GRP_ALU;
        info_o[`EXU_ALU_LUI] = 1'b1;
        rd_we_o              = 1'b1;
        op2_o                = imm_u;
      end
      OPC_JAL: begin
        // link value pc + 4 comes out of the alu adder
        info_o[2:0]           = `EXU_GRP_BJP;
        info_o[`EXU_BJP_JAL]  = 1'b1;
        rd_we_o               = 1'b1;
        op1_o                 = pc_i;
        op2_o                 = xlen_t'(4);
        op2_jp_o              = imm_j;
      end
      OPC_JALR: begin
        info_o[2:0]           = `EXU_GRP_BJP;
        info_o[`EXU_BJP_JALR] = 1'b1;
        rd_we_o               = 1'b1;
        op1_o                 = pc_i;
        op2_o                 = xlen_t'(4);
        op1_jp_o              = rs1_data_i;
        op2_jp_o              = imm_i;
        illegal_o             = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        info_o[2:0] = `EXU_GRP_BJP;
        case (funct3)
          3'b000:  info_o[`EXU_BJP_BEQ]  = 1'b1;
          3'b001:  info_o[`EXU_BJP_BNE]  = 1'b1;
          3'b100:  info_o[`EXU_BJP_BLT]  = 1'b1;
          3'b101:  info_o[`EXU_BJP_BGE]  = 1'b1;
          3'b110:  info_o[`EXU_BJP_BLTU] = 1'b1;
          3'b111:  info_o[`EXU_BJP_BGEU] = 1'b1;
          default: illegal_o             = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        // only ebreak is kept from the system space
        if (inst_i == 32'h00100073) info_o[`EXU_EBREAK] = 1'b1;
        else illegal_o = 1'b1;
      end
      default: illegal_o = 1'b1;
    endcase
    // an illegal word must not jump or write
    if (illegal_o) begin
      info_o  = '0;
      rd_we_o = 1'b0;
    end else if (rd_idx_o == '0) begin
      rd_we_o = 1'b0;
    end
  end

endmodule

// ==== design/fetch_unit.sv ====
`include "rv_core_macros.svh"

module fetch_unit import rv_core_pkg::*; (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  ibus_ack_i,
  input  inst_t ibus_dat_i,
  input  logic  jump_i,
  input  xlen_t jump_addr_i,
  input  logic  stop_i,
  input  logic  illegal_i,
  output logic  ibus_cyc_o,
  output logic  ibus_stb_o,
  output xlen_t ibus_adr_o,
  output inst_t inst_o,
  output xlen_t pc_o,
  output logic  exec_o,
  output logic  halt_o,
  output logic  illegal_o
);

  fetch_state_e state_q;
  xlen_t        pc_q;
  inst_t        inst_q;
  logic         illegal_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= IDLE;
      pc_q      <= `RV_RESET_PC;
      illegal_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: state_q <= BUS;
        BUS: begin
          // wait here as long as the slave withholds ack
          if (ibus_ack_i) begin
            state_q <= EXEC;
          end
        end
        EXEC: begin
          pc_q <= jump_i ? jump_addr_i : pc_q + xlen_t'(4);
          if (stop_i || illegal_i) begin
            state_q <= HALT;
          end else begin
            state_q <= BUS;
          end
          // sticky until reset
          if (illegal_i) begin
            illegal_q <= 1'b1;
          end
        end
        default: state_q <= HALT;
      endcase
    end
  end

  // instruction word taken on the ack edge
  always_ff @(posedge clk) begin
    if (state_q == BUS && ibus_ack_i) begin
      inst_q <= ibus_dat_i;
    end
  end

  assign ibus_cyc_o = (state_q == BUS);
  assign ibus_stb_o = (state_q == BUS);
  assign ibus_adr_o = pc_q;
  assign inst_o     = inst_q;
  assign pc_o       = pc_q;
  assign exec_o     = (state_q == EXEC);
  assign halt_o     = (state_q == HALT);
  assign illegal_o  = illegal_q;

endmodule

// ==== design/rv_core_pkg.sv ====
`include "rv_core_macros.svh"

package rv_core_pkg;

  // register or address value
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // raw instruction word
  typedef logic [31:0] inst_t;

  // register file index
  typedef logic [4:0] reg_idx_t;

  // decoded operation with the group code in the low bits
  typedef logic [`EXU_INFO_W-1:0] exu_info_t;

  // fetch sequencer
  typedef enum logic [1:0] {
    IDLE,
    BUS,
    EXEC,
    HALT
  } fetch_state_e;

endpackage

// ==== design/rv_core_macros.svh ====
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data and address width
`define RV_XLEN       64
`define RV_RESET_PC   64'h0

// execute information bus
`define EXU_INFO_W    15

// group codes in bits 2:0
`define EXU_GRP_ALU   3'd1
`define EXU_GRP_BJP   3'd2
`define EXU_EBREAK    3

// alu group operation bits
`define EXU_ALU_ADD   4
`define EXU_ALU_SUB   5
`define EXU_ALU_SLL   6
`define EXU_ALU_SLT   7
`define EXU_ALU_SLTU  8
`define EXU_ALU_XOR   9
`define EXU_ALU_SRL   10
`define EXU_ALU_SRA   11
`define EXU_ALU_OR    12
`define EXU_ALU_AND   13
`define EXU_ALU_LUI   14

// branch/jump group reuses bits 4 to 11
`define EXU_BJP_JAL   4
`define EXU_BJP_JALR  5
`define EXU_BJP_BEQ   6
`define EXU_BJP_BNE   7
`define EXU_BJP_BLT   8
`define EXU_BJP_BGE   9
`define EXU_BJP_BLTU  10
`define EXU_BJP_BGEU  11

`endif
